// File: Bender.yml
package:
  name: sprite_render

sources:
  - include_dirs:
      - .
    files:
      - sprite_obj_pkg.sv
      - sprite_pix_pkg.sv
      - sprite_fetch.sv
      - line_bank.sv
      - scan_merge.sv
      - sprite_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sprite_checker.sv
      - sprite_tb.sv

// File: build.f
+incdir+.
sprite_obj_pkg.sv
sprite_pix_pkg.sv
sprite_fetch.sv
line_bank.sv
scan_merge.sv
sprite_top.sv
sprite_checker.sv
sprite_tb.sv

// File: line_bank.sv
// One line buffer bank, takes 16-pixel row writes and is read and cleared during scan-out
`timescale 1ns/1ns
`include "sprite_params.svh"

module line_bank
    import sprite_pix_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_en,
    input  logic [9:0]  wr_x,
    input  logic [63:0] wr_row,
    input  logic [6:0]  wr_palette,
    input  logic        wr_flip_x,
    input  logic        rd_en,
    input  pix_x_t      rd_x,
    output pix_entry_t  rd_pix
);

    pix_entry_t mem [0:`SPR_LINE_W-1];

    logic   clr_busy;
    pix_x_t clr_x;
    logic   rd_en_q;
    pix_x_t rd_x_q;

    // Sweep that empties every entry after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            clr_busy <= 1'b1;
            clr_x <= '0;
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= rd_en;
            if (clr_busy) begin
                clr_x <= clr_x + 1'b1;
                if (clr_x == pix_x_t'(`SPR_LINE_W - 1)) begin
                    clr_busy <= 1'b0;
                end
            end
        end
    end

    // ==============================
    // Storage, write merge and clear
    // ==============================
    always_ff @(posedge clk) begin
        logic [3:0]  nib;
        logic [10:0] pos;
        if (clr_busy) begin
            mem[clr_x] <= '0;
        end else begin
            if (wr_en) begin
                for (int i = 0; i < 16; i++) begin
                    nib = wr_row[4*i +: 4];
                    pos = wr_flip_x ? {1'b0, wr_x} + 11'(15 - i) : {1'b0, wr_x} + 11'(i);
                    // Earlier objects in the table keep their opaque pixels
                    if (nib != 4'd0 && pos < 11'(`SPR_LINE_W) && mem[pos[8:0]].index == 4'd0) begin
                        mem[pos[8:0]] <= '{palette: wr_palette, index: nib};
                    end
                end
            end
            if (rd_en_q) begin
                mem[rd_x_q] <= '0;
            end
        end
        if (rd_en) begin
            rd_pix <= mem[rd_x];
            rd_x_q <= rd_x;
        end
    end

endmodule

// File: scan_merge.sv
// Scan-out stage that steps the line position, picks the read bank, mirrors and fills background
`timescale 1ns/1ns
`include "sprite_params.svh"

module scan_merge
    import sprite_pix_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pix_ce,
    input  logic       line_start,
    input  logic       screen_flip,
    input  pix_color_t bg_color,
    output logic       rd_en,
    output pix_x_t     rd_x,
    input  pix_entry_t rd_pix_0,
    input  pix_entry_t rd_pix_1,
    output pix_color_t pix_color,
    output logic       pix_valid
);

    pix_x_t     scan_x;
    logic       rd_bank;
    logic       sel_q;
    logic       rd_en_q;
    pix_entry_t pix_sel;

    // The scan stops once the position reaches the end of the visible line
    assign rd_en = pix_ce && !line_start && (scan_x < pix_x_t'(`SPR_LINE_W));
    assign rd_x = screen_flip ? pix_x_t'(`SPR_LINE_W - 1) - scan_x : scan_x;
    assign pix_sel = sel_q ? rd_pix_1 : rd_pix_0;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Parked past the line end so no read happens before the first line start
            scan_x <= pix_x_t'(`SPR_LINE_W);
            rd_bank <= 1'b1;
            rd_en_q <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            rd_en_q <= rd_en;
            pix_valid <= rd_en_q;
            if (line_start) begin
                scan_x <= pix_x_t'(`SPR_SCAN_START);
                rd_bank <= ~rd_bank;
            end else if (rd_en) begin
                scan_x <= scan_x + 1'b1;
            end
        end
    end

    // Bank choice travels with the read so a line start cannot split a pixel
    always_ff @(posedge clk) begin
        if (rd_en) begin
            sel_q <= rd_bank;
        end
        if (rd_en_q) begin
            pix_color <= (pix_sel.index == 4'd0) ? bg_color : pix_color_t'(pix_sel);
        end
    end

endmodule

// File: sprite_checker.sv
// Testbench checker that rebuilds each rendered line from the object rules and compares the pixels
`timescale 1ns/1ns
`include "sprite_params.svh"

module sprite_checker
    import sprite_obj_pkg::*;
    import sprite_pix_pkg::*;
#(
    parameter int LINE_CYCLES = 900
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               line_start,
    input  logic [8:0]                         line_num,
    input  logic                               screen_flip,
    input  pix_color_t                         bg_color,
    input  obj_desc_t [`SPR_OBJ_COUNT-1:0]     obj_tab,
    input  logic [7:0]                         test_num,
    input  logic                               pix_valid,
    input  pix_color_t                         pix_color,
    output int                                 err_count,
    output int                                 pix_total
);

    obj_desc_t  tab_copy [0:`SPR_OBJ_COUNT-1];
    pix_entry_t pend_line [0:`SPR_LINE_W-1];
    pix_entry_t shown_line [0:`SPR_LINE_W-1];
    logic [31:0] lcg_state = 32'd89;
    int         carry = 0;
    bit         pend_valid;
    bit         shown_valid;
    logic [7:0] pend_test;
    logic [7:0] shown_test;
    logic       scan_flip;
    pix_color_t scan_bg;
    int         line_pix;
    int         test_lines;
    int         test_err;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Same ack delay sequence as the memory model, one draw per bus read
    function automatic int draw_delay();
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[17:16]);
    endfunction

    function automatic logic [63:0] row_hash(input logic [23:0] adr);
        logic [63:0] h;
        h = {40'd0, adr} * 64'h9E37_79B9_7F4A_7C15;
        h = h ^ (h >> 31);
        return h & {h[3:0], h[63:4]};
    endfunction

    // Writes one fetched row into the expected line, first opaque pixel wins
    function automatic void put_row(input logic [9:0] x, input logic [63:0] row,
                                    input logic [6:0] pal, input logic fx);
        int pos;
        logic [3:0] nib;
        for (int i = 0; i < 16; i++) begin
            nib = row[4*i +: 4];
            pos = fx ? int'(x) + 15 - i : int'(x) + i;
            if (nib != 4'd0 && pos < `SPR_LINE_W && pend_line[pos].index == 4'd0) begin
                pend_line[pos] = '{palette: pal, index: nib};
            end
        end
    endfunction

    // ==============================
    // Reference line with walk timing
    // ==============================
    // Edge counts run from the line start edge, the walk is cut at the next one
    function automatic void build_line(input logic [8:0] ln);
        obj_desc_t   d;
        int          t;
        int          ack;
        int          ht;
        int          wd;
        int          rel;
        int          src;
        int          col;
        logic [15:0] code_sum;
        logic [23:0] adr;
        bit          done;
        for (int i = 0; i < `SPR_LINE_W; i++) begin
            pend_line[i] = '0;
        end
        t = carry + 1;
        carry = 0;
        done = 0;
        for (int slot = 0; slot < `SPR_OBJ_COUNT && !done; slot++) begin
            d = tab_copy[slot];
            if (t >= LINE_CYCLES) begin
                done = 1;
            end else begin
                ack = t + draw_delay() + 1;
                if (ack >= LINE_CYCLES) begin
                    carry = ack - LINE_CYCLES;
                    done = 1;
                end else begin
                    t = ack + 1;
                    ht = 16 << d.h;
                    wd = 1 << d.w;
                    rel = (int'(ln) + int'(d.org_y) + ht) % 512;
                    if (d.end_flag) begin
                        done = 1;
                    end else if (rel < ht) begin
                        src = d.flip.y ? ht - 1 - rel : rel;
                        for (int s = 0; s < wd && !done; s++) begin
                            if (t >= LINE_CYCLES) begin
                                done = 1;
                            end else begin
                                ack = t + draw_delay() + 1;
                                if (ack >= LINE_CYCLES) begin
                                    carry = ack - LINE_CYCLES;
                                    done = 1;
                                end else begin
                                    t = ack + 1;
                                    col = d.flip.x ? wd - 1 - s : s;
                                    code_sum = d.code + 16'(src / 16) + 16'(8 * col);
                                    adr = `SPR_GFX_BASE + {4'd0, code_sum, 4'(src % 16)};
                                    put_row(10'(int'(d.org_x) + 16 * s), row_hash(adr),
                                            d.palette, d.flip.x);
                                end
                            end
                        end
                    end
                end
            end
        end
    endfunction

    always @(posedge clk) begin
        pix_entry_t e;
        pix_color_t exp;
        int xpos;
        if (reset) begin
            // The first line after reset scans a bank that the sweep has emptied
            for (int i = 0; i < `SPR_LINE_W; i++) begin
                pend_line[i] = '0;
            end
            pend_valid = 1;
            shown_valid = 0;
            pend_test = '0;
            shown_test = '0;
            line_pix = 0;
            err_count = 0;
            pix_total = 0;
            test_lines = 0;
            test_err = 0;
        end else begin
            if (line_start) begin
                if (shown_valid && line_pix != `SPR_LINE_W) begin
                    $display("[FAIL] t=%0t a line of test %0d delivered %0d pixels, not %0d",
                             $time, shown_test, line_pix, `SPR_LINE_W);
                    err_count++;
                    test_err++;
                end
                if (pend_valid && pend_test != shown_test) begin
                    if (shown_test != 0) begin
                        $display("test %0d finished: %0d lines, %0d errors",
                                 shown_test, test_lines, test_err);
                    end
                    test_lines = 0;
                    test_err = 0;
                end
                for (int i = 0; i < `SPR_LINE_W; i++) begin
                    shown_line[i] = pend_line[i];
                end
                shown_valid = pend_valid;
                shown_test = pend_test;
                if (shown_valid) begin
                    test_lines++;
                end
                scan_flip = screen_flip;
                scan_bg = bg_color;
                line_pix = 0;
                for (int i = 0; i < `SPR_OBJ_COUNT; i++) begin
                    tab_copy[i] = obj_tab[i];
                end
                build_line(line_num);
                pend_valid = 1;
                pend_test = test_num;
            end
            if (pix_valid && shown_valid) begin
                xpos = scan_flip ? `SPR_LINE_W - 1 - line_pix : line_pix;
                e = shown_line[xpos];
                exp = (e.index == 4'd0) ? scan_bg : pix_color_t'(e);
                if (pix_color !== exp) begin
                    if (test_err < 10) begin
                        $display("[FAIL] t=%0t pix_color x=%0d expected %h got %h",
                                 $time, line_pix, exp, pix_color);
                    end
                    err_count++;
                    test_err++;
                end
                line_pix++;
                pix_total++;
            end else if (pix_valid) begin
                $display("[FAIL] t=%0t pix_valid expected 0 got 1 before the first line start",
                         $time);
                err_count++;
                test_err++;
            end
        end
    end

endmodule

// File: sprite_fetch.sv
// Per-line object walker that reads descriptors and graphics over Wishbone and emits row writes
`timescale 1ns/1ns
`include "sprite_params.svh"

module sprite_fetch
    import sprite_obj_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        line_start,
    input  logic [8:0]  line_num,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [23:0] wb_adr,
    input  logic [63:0] wb_dat_i,
    input  logic        wb_ack,
    output logic        wr_en,
    output logic        wr_bank,
    output logic [9:0]  wr_x,
    output logic [63:0] wr_row,
    output logic [6:0]  wr_palette,
    output logic        wr_flip_x
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DESC,
        S_EVAL,
        S_ROW,
        S_WRITE
    } state_t;

    state_t     state;
    obj_idx_t   slot;
    logic [3:0] span;
    logic       abandon;
    logic [8:0] line_next;
    logic [8:0] line_q;
    obj_desc_t  desc;

    logic [8:0]  height;
    logic [3:0]  width;
    logic [8:0]  rel_y;
    logic [8:0]  src_y;
    logic        visible;
    logic [3:0]  col;
    logic [15:0] code_sum;
    logic        bus_busy;
    logic        last_span;
    logic        last_slot;

    // ==============================
    // Visibility and address decode
    // ==============================
    assign height = 9'd16 << desc.h;
    assign width = 4'd1 << desc.w;
    // Wraps modulo 512, so lines above the object come out at or above the height
    assign rel_y = line_q + desc.org_y + height;
    assign visible = rel_y < height;
    assign src_y = desc.flip.y ? height - 9'd1 - rel_y : rel_y;
    assign col = desc.flip.x ? width - 4'd1 - span : span;
    // Each 16-row block of a column steps one code, columns are 8 codes apart
    assign code_sum = desc.code + {11'd0, src_y[8:4]} + {9'd0, col, 3'd0};

    // The bus cycle lasts exactly as long as a read state
    assign bus_busy = (state == S_DESC) || (state == S_ROW);
    assign wb_cyc = bus_busy;
    assign wb_stb = bus_busy;
    assign wb_adr = (state == S_ROW) ? `SPR_GFX_BASE + {4'd0, code_sum, src_y[3:0]}
                                     : `SPR_OBJ_BASE + 24'(slot);

    assign wr_en = (state == S_WRITE);
    assign last_span = (span == width - 4'd1);
    assign last_slot = (slot == obj_idx_t'(`SPR_OBJ_COUNT - 1));

    // ==============================
    // Walk control
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            slot <= '0;
            span <= '0;
            abandon <= 1'b0;
            wr_bank <= 1'b0;
            line_next <= '0;
            line_q <= '0;
        end else if (line_start) begin
            line_next <= line_num;
            wr_bank <= ~wr_bank;
            // A pending read must run to its ack before the walk restarts
            if (bus_busy && !wb_ack) begin
                abandon <= 1'b1;
            end else begin
                abandon <= 1'b0;
                state <= S_START;
            end
        end else begin
            case (state)
                S_START: begin
                    line_q <= line_next;
                    slot <= '0;
                    span <= '0;
                    state <= S_DESC;
                end
                S_DESC: begin
                    if (wb_ack) begin
                        abandon <= 1'b0;
                        state <= abandon ? S_START : S_EVAL;
                    end
                end
                S_EVAL: begin
                    if (desc.end_flag) begin
                        state <= S_IDLE;
                    end else if (visible) begin
                        span <= '0;
                        state <= S_ROW;
                    end else if (last_slot) begin
                        state <= S_IDLE;
                    end else begin
                        slot <= slot + 1'b1;
                        state <= S_DESC;
                    end
                end
                S_ROW: begin
                    if (wb_ack) begin
                        abandon <= 1'b0;
                        state <= abandon ? S_START : S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (!last_span) begin
                        span <= span + 4'd1;
                        state <= S_ROW;
                    end else if (last_slot) begin
                        state <= S_IDLE;
                    end else begin
                        slot <= slot + 1'b1;
                        state <= S_DESC;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Descriptor and row data captured on the ack of their read
    always_ff @(posedge clk) begin
        if (state == S_DESC && wb_ack) begin
            desc <= wb_dat_i;
        end
        if (state == S_ROW && wb_ack) begin
            wr_row <= wb_dat_i;
            wr_x <= desc.org_x + {2'd0, span, 4'd0};
            wr_palette <= desc.palette;
            wr_flip_x <= desc.flip.x;
        end
    end

endmodule

// File: sprite_obj_pkg.sv
// Object table types, imported by the fetch engine and the checker to decode 64-bit descriptors
`include "sprite_params.svh"

package sprite_obj_pkg;

    // Size code, height is 16 << h pixels and width is 1 << w spans
    typedef logic [1:0] obj_size_t;

    typedef struct packed {
        logic y;
        logic x;
    } obj_flip_t;

    // Index of a descriptor slot in the table
    typedef logic [$clog2(`SPR_OBJ_COUNT)-1:0] obj_idx_t;

    // ==============================
    // Descriptor layout, bit 0 is org_y[0]
    // ==============================
    typedef struct packed {
        logic [5:0]  rsvd_hi;
        logic [9:0]  org_x;
        logic [5:0]  rsvd_mid;
        obj_flip_t   flip;
        // Set on the last descriptor, which stops the walk and is not drawn
        logic        end_flag;
        logic [6:0]  palette;
        logic [15:0] code;
        logic [2:0]  rsvd_lo;
        obj_size_t   w;
        obj_size_t   h;
        logic [8:0]  org_y;
    } obj_desc_t;

endpackage

// File: sprite_params.svh
// Sizes, memory bases and scan timing of the sprite renderer, included by packages, RTL and testbench
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// Number of descriptor slots in the object table
`define SPR_OBJ_COUNT 32

// Wishbone word addresses of the object table and the graphics region
`define SPR_OBJ_BASE 24'h000000
`define SPR_GFX_BASE 24'h100000

// Visible pixels per line, sets the x range of the line buffer banks
`define SPR_LINE_W 320

// Scan position loaded on each line start
`define SPR_SCAN_START 0

`endif

// File: sprite_pix_pkg.sv
// Pixel types, imported by the line buffer banks, the scan merge stage and the checker
`include "sprite_params.svh"

package sprite_pix_pkg;

    // Position within the visible line
    typedef logic [$clog2(`SPR_LINE_W)-1:0] pix_x_t;

    // Stored line buffer pixel, an index of 0 marks the entry as empty
    typedef struct packed {
        logic [6:0] palette;
        logic [3:0] index;
    } pix_entry_t;

    // Colour presented on the pixel output
    typedef logic [10:0] pix_color_t;

endpackage

// File: sprite_tb.sv
// Testbench top for the sprite renderer with clock, line timing, Wishbone memory model and stimulus
`timescale 1ns/1ns
`include "sprite_params.svh"

module sprite_tb
    import sprite_obj_pkg::*;
    import sprite_pix_pkg::*;
;

    localparam int LINE_CYCLES = 900;
    localparam int LINE_COUNT = 24;
    localparam int TIMEOUT = LINE_COUNT * LINE_CYCLES + 2000;

    logic        clk;
    logic        reset;
    logic        pix_ce;
    logic        line_start;
    logic [8:0]  line_num;
    logic        screen_flip;
    pix_color_t  bg_color;
    logic        wb_cyc;
    logic        wb_stb;
    logic [23:0] wb_adr;
    logic [63:0] wb_dat_i;
    logic        wb_ack;
    logic        wb_we;
    pix_color_t  pix_color;
    logic        pix_valid;
    logic [7:0]  test_num;
    int          err_count;
    int          pix_total;
    int          cycles;

    obj_desc_t [`SPR_OBJ_COUNT-1:0] obj_tab;
    obj_desc_t [`SPR_OBJ_COUNT-1:0] next_tab;

    logic [31:0] lcg_state;
    bit          pending;
    int          wait_n;

    sprite_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .pix_ce      (pix_ce),
        .line_start  (line_start),
        .line_num    (line_num),
        .screen_flip (screen_flip),
        .bg_color    (bg_color),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .pix_color   (pix_color),
        .pix_valid   (pix_valid)
    );

    sprite_checker #(.LINE_CYCLES(LINE_CYCLES)) checker_i (
        .clk         (clk),
        .reset       (reset),
        .line_start  (line_start),
        .line_num    (line_num),
        .screen_flip (screen_flip),
        .bg_color    (bg_color),
        .obj_tab     (obj_tab),
        .test_num    (test_num),
        .pix_valid   (pix_valid),
        .pix_color   (pix_color),
        .err_count   (err_count),
        .pix_total   (pix_total)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Graphics rows are a hash of the word address, about a third of the nibbles are zero
    function automatic logic [63:0] row_hash(input logic [23:0] adr);
        logic [63:0] h;
        h = {40'd0, adr} * 64'h9E37_79B9_7F4A_7C15;
        h = h ^ (h >> 31);
        return h & {h[3:0], h[63:4]};
    endfunction

    function automatic logic [63:0] mem_read(input logic [23:0] adr);
        if (adr >= `SPR_GFX_BASE) begin
            return row_hash(adr);
        end else if (adr - `SPR_OBJ_BASE < `SPR_OBJ_COUNT) begin
            return obj_tab[adr - `SPR_OBJ_BASE];
        end
        return 64'd0;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // Wishbone memory model
    // ==============================
    // Each read waits 0 to 3 cycles drawn from the LCG before ack
    assign wb_we = 1'b0;

    always @(negedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            pending = 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb && !wb_we) begin
            if (!pending) begin
                lcg_state = lcg_next(lcg_state);
                wait_n = int'(lcg_state[17:16]);
                pending = 1;
            end
            if (wait_n == 0) begin
                wb_ack <= 1'b1;
                wb_dat_i <= mem_read(wb_adr);
                pending = 0;
            end else begin
                wait_n--;
            end
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            pix_ce <= 1'b0;
        end else begin
            pix_ce <= ~pix_ce;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Places an object by its top line, org_y holds minus top minus height
    task automatic set_obj(input int slot, input int x, input int top, input int h, input int w,
                           input int code, input int pal, input bit fx, input bit fy);
        obj_desc_t d;
        d = '0;
        d.org_x = 10'(x);
        d.org_y = 9'(1024 - top - (16 << h));
        d.h = 2'(h);
        d.w = 2'(w);
        d.code = 16'(code);
        d.palette = 7'(pal);
        d.flip.x = fx;
        d.flip.y = fy;
        next_tab[slot] = d;
    endtask

    task automatic set_end(input int slot);
        next_tab[slot] = '0;
        next_tab[slot].end_flag = 1'b1;
    endtask

    // The table changes together with line_start so a running walk never sees it
    task automatic run_line(input logic [7:0] test, input int ln, input logic flip, input int bg);
        @(negedge clk);
        obj_tab = next_tab;
        line_num = 9'(ln);
        screen_flip = flip;
        bg_color = 11'(bg);
        test_num = test;
        line_start = 1'b1;
        @(negedge clk);
        line_start = 1'b0;
        repeat (LINE_CYCLES - 2) @(negedge clk);
    endtask

    initial begin
        reset = 1'b1;
        pix_ce = 1'b0;
        line_start = 1'b0;
        line_num = '0;
        screen_flip = 1'b0;
        bg_color = '0;
        wb_ack = 1'b0;
        wb_dat_i = '0;
        test_num = '0;
        obj_tab = '0;
        next_tab = '0;
        lcg_state = 32'd89;
        cycles = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // Let the bank clear sweep finish
        repeat (400) @(negedge clk);

        set_obj(0, 40, 20, 0, 0, 'h10, 5, 0, 0);
        set_end(1);
        run_line(1, 18, 0, 'h1a0);
        run_line(1, 20, 0, 'h1a0);
        run_line(1, 35, 0, 'h1a0);
        run_line(1, 36, 0, 'h1a0);
        set_obj(0, 40, 100, 0, 0, 'h10, 5, 0, 0);
        run_line(1, 100, 0, 'h1a0);
        run_line(1, 116, 0, 'h1a0);

        set_obj(0, 10, 50, 3, 3, 'h200, 9, 1, 0);
        set_obj(1, 200, 60, 2, 1, 'h300, 17, 0, 1);
        set_obj(2, 150, 40, 1, 2, 'h400, 33, 1, 1);
        set_obj(3, 280, 70, 0, 0, 'h500, 65, 0, 1);
        set_end(4);
        run_line(2, 50, 0, 'h2b1);
        run_line(2, 70, 0, 'h2b1);
        run_line(2, 75, 0, 'h2b1);
        run_line(2, 100, 0, 'h2b1);
        run_line(2, 120, 0, 'h2b1);
        run_line(2, 177, 0, 'h2b1);

        set_obj(0, 100, 10, 0, 1, 'h20, 3, 0, 0);
        set_obj(1, 108, 12, 1, 1, 'h40, 4, 1, 0);
        set_obj(2, 96, 10, 0, 0, 'h60, 6, 0, 1);
        set_end(3);
        run_line(3, 12, 0, 'h0c2);
        run_line(3, 20, 0, 'h0c2);
        run_line(3, 25, 0, 'h0c2);

        set_obj(0, 310, 0, 0, 1, 'h80, 7, 0, 0);
        set_obj(1, 0, 0, 0, 0, 'h90, 8, 1, 0);
        set_end(2);
        run_line(4, 5, 1, 'h3d3);
        run_line(4, 10, 1, 'h3d3);

        set_obj(0, 60, 30, 0, 0, 'h30, 11, 0, 0);
        set_end(1);
        set_obj(2, 160, 30, 0, 0, 'h50, 12, 0, 0);
        run_line(5, 30, 0, 'h0e4);
        run_line(5, 35, 0, 'h0e4);

        // Full table of 8-span objects, the walk runs past the line period
        for (int s = 0; s < `SPR_OBJ_COUNT; s++) begin
            set_obj(s, s * 9, 0, 3, 3, s * 16, s + 1, s[0], s[1]);
        end
        run_line(6, 10, 0, 'h1f5);
        run_line(6, 40, 0, 'h1f5);
        run_line(6, 90, 0, 'h1f5);

        next_tab = '0;
        set_end(0);
        run_line(0, 0, 0, 'h000);
        run_line(0, 0, 0, 'h000);

        $display("Checked %0d pixels, %0d errors", pix_total, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sprite_top.sv
// Sprite renderer top level joining the fetch engine, two line buffer banks and the scan stage
`timescale 1ns/1ns

module sprite_top
    import sprite_pix_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pix_ce,
    input  logic        line_start,
    input  logic [8:0]  line_num,
    input  logic        screen_flip,
    input  pix_color_t  bg_color,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [23:0] wb_adr,
    input  logic [63:0] wb_dat_i,
    input  logic        wb_ack,
    output pix_color_t  pix_color,
    output logic        pix_valid
);

    logic        wr_en;
    logic        wr_bank;
    logic [9:0]  wr_x;
    logic [63:0] wr_row;
    logic [6:0]  wr_palette;
    logic        wr_flip_x;
    logic        rd_en;
    pix_x_t      rd_x;
    pix_entry_t  rd_pix_0;
    pix_entry_t  rd_pix_1;

    sprite_fetch fetch_i (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .line_num   (line_num),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .wr_en      (wr_en),
        .wr_bank    (wr_bank),
        .wr_x       (wr_x),
        .wr_row     (wr_row),
        .wr_palette (wr_palette),
        .wr_flip_x  (wr_flip_x)
    );

    // ==============================
    // Double line buffer
    // ==============================
    // Writes go to the bank named by wr_bank, scan reads to the other one
    line_bank bank_0 (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en & ~wr_bank),
        .wr_x       (wr_x),
        .wr_row     (wr_row),
        .wr_palette (wr_palette),
        .wr_flip_x  (wr_flip_x),
        .rd_en      (rd_en & wr_bank),
        .rd_x       (rd_x),
        .rd_pix     (rd_pix_0)
    );

    line_bank bank_1 (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en & wr_bank),
        .wr_x       (wr_x),
        .wr_row     (wr_row),
        .wr_palette (wr_palette),
        .wr_flip_x  (wr_flip_x),
        .rd_en      (rd_en & ~wr_bank),
        .rd_x       (rd_x),
        .rd_pix     (rd_pix_1)
    );

    scan_merge merge_i (
        .clk         (clk),
        .reset       (reset),
        .pix_ce      (pix_ce),
        .line_start  (line_start),
        .screen_flip (screen_flip),
        .bg_color    (bg_color),
        .rd_en       (rd_en),
        .rd_x        (rd_x),
        .rd_pix_0    (rd_pix_0),
        .rd_pix_1    (rd_pix_1),
        .pix_color   (pix_color),
        .pix_valid   (pix_valid)
    );

endmodule
